// File: llc_pkg.sv
////////////////////////////////////////////////////////////////////////////
// widths, types and tag-word layout shared by the LLC local memory blocks
////////////////////////////////////////////////////////////////////////////

package llc_pkg;

    parameter int LLC_SET_BITS = 4;
    parameter int LLC_SETS = 1 << LLC_SET_BITS;
    // way number is sized for up to 8 ways
    parameter int LLC_WAY_BITS = 3;
    parameter int LLC_WAYS = 4;
    parameter int LLC_TAG_BITS = 8;
    parameter int LLC_STATE_BITS = 3;
    parameter int OWNER_BITS = 2;
    parameter int LINE_BITS = 32;

    typedef logic [LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [LLC_WAY_BITS-1:0] llc_way_t;
    typedef logic [LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [LLC_STATE_BITS-1:0] llc_state_t;
    typedef logic [OWNER_BITS-1:0] owner_t;
    typedef logic [LINE_BITS-1:0] line_t;

    typedef enum logic [1:0] {
        OP_LOOKUP = 2'd0,
        OP_FILL = 2'd1,
        OP_SET_STATE = 2'd2,
        OP_SET_EVICT = 2'd3
    } llc_op_t;

    // tag-store word, msb to lsb: dirty, state, owner, tag
    parameter int MIXED_BITS = 1 + LLC_STATE_BITS + OWNER_BITS + LLC_TAG_BITS;
    parameter int MIXED_TAG_LO = 0;
    parameter int MIXED_TAG_HI = MIXED_TAG_LO + LLC_TAG_BITS - 1;
    parameter int MIXED_OWNER_LO = MIXED_TAG_HI + 1;
    parameter int MIXED_OWNER_HI = MIXED_OWNER_LO + OWNER_BITS - 1;
    parameter int MIXED_STATE_LO = MIXED_OWNER_HI + 1;
    parameter int MIXED_STATE_HI = MIXED_STATE_LO + LLC_STATE_BITS - 1;
    parameter int MIXED_DIRTY_INDEX = MIXED_STATE_HI + 1;

endpackage

// File: llc_mem_if.sv
////////////////////////////////////////////////////////////////////////////
// one accepted request as seen by the tag store, data store and selector
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface llc_mem_if;

    logic valid;
    llc_pkg::llc_op_t op;
    llc_pkg::llc_set_t set;
    llc_pkg::llc_way_t way;
    llc_pkg::llc_tag_t tag;
    llc_pkg::llc_state_t state;
    logic dirty;
    llc_pkg::owner_t owner;
    llc_pkg::line_t line;
    llc_pkg::llc_way_t evict_way;

    modport issue (
        output valid, op, set, way, tag, state, dirty, owner, line, evict_way
    );

    modport store (
        input valid, op, set, way, tag, state, dirty, owner, line, evict_way
    );

    // selector only needs what it must delay to meet the read data
    modport sel (
        input valid, op, tag
    );

endinterface

// File: llc_sram_sp.sv
////////////////////////////////////////////////////////////////////////////
// behavioral single-port SRAM with bit write mask, read-first on a write
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module llc_sram_sp #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input logic clk,
    input logic ce,
    input logic we,
    input logic [$clog2(DEPTH)-1:0] addr,
    input logic [WIDTH-1:0] wdata,
    input logic [WIDTH-1:0] wmask,
    output logic [WIDTH-1:0] rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // contents stay undefined until written, as in the macro
    always_ff @(posedge clk) begin
        if (ce) begin
            if (we) begin
                mem[addr] <= (mem[addr] & ~wmask) | (wdata & wmask);
            end
            rdata <= mem[addr];
        end
    end

endmodule

// File: llc_tag_store.sv
////////////////////////////////////////////////////////////////////////////
// per-way tag/state/owner/dirty SRAMs and the per-set eviction pointers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module llc_tag_store #(
    parameter int NUM_WAYS = llc_pkg::LLC_WAYS
) (
    input logic clk,
    input logic rst,
    llc_mem_if.store req,
    output logic [llc_pkg::MIXED_BITS-1:0] rd_mixed [NUM_WAYS],
    output llc_pkg::llc_way_t rd_evict_way
);

    logic [llc_pkg::MIXED_BITS-1:0] wr_word;
    logic [llc_pkg::MIXED_BITS-1:0] wr_mask;
    logic wr_tag;
    llc_pkg::llc_way_t evict_way_arr [llc_pkg::LLC_SETS];

    assign wr_tag = req.valid &&
        (req.op == llc_pkg::OP_FILL || req.op == llc_pkg::OP_SET_STATE);

    // field order matches the MIXED_* positions
    assign wr_word = {req.dirty, req.state, req.owner, req.tag};

    // set_state only touches state and dirty, like a flush
    always_comb begin
        wr_mask = '0;
        wr_mask[llc_pkg::MIXED_DIRTY_INDEX] = 1'b1;
        wr_mask[llc_pkg::MIXED_STATE_HI:llc_pkg::MIXED_STATE_LO] = '1;
        if (req.op == llc_pkg::OP_FILL) begin
            wr_mask[llc_pkg::MIXED_OWNER_HI:llc_pkg::MIXED_OWNER_LO] = '1;
            wr_mask[llc_pkg::MIXED_TAG_HI:llc_pkg::MIXED_TAG_LO] = '1;
        end
    end

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
        llc_sram_sp #(
            .WIDTH(llc_pkg::MIXED_BITS),
            .DEPTH(llc_pkg::LLC_SETS)
        ) mixed_sram (
            .clk(clk),
            .ce(req.valid),
            .we(wr_tag && req.way == llc_pkg::llc_way_t'(i)),
            .addr(req.set),
            .wdata(wr_word),
            .wmask(wr_mask),
            .rdata(rd_mixed[i])
        );
    end

    // a set_evict reports the pointer it just stored
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < llc_pkg::LLC_SETS; s++) begin
                evict_way_arr[s] <= '0;
            end
            rd_evict_way <= '0;
        end else if (req.valid) begin
            if (req.op == llc_pkg::OP_SET_EVICT) begin
                evict_way_arr[req.set] <= req.evict_way;
                rd_evict_way <= req.evict_way;
            end else begin
                rd_evict_way <= evict_way_arr[req.set];
            end
        end
    end

endmodule

// File: llc_data_store.sv
////////////////////////////////////////////////////////////////////////////
// per-way line SRAMs, all ways of a set read together on every request
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module llc_data_store #(
    parameter int NUM_WAYS = llc_pkg::LLC_WAYS
) (
    input logic clk,
    llc_mem_if.store req,
    output llc_pkg::line_t rd_line [NUM_WAYS]
);

    logic wr_line;

    assign wr_line = req.valid && req.op == llc_pkg::OP_FILL;

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
        // whole line written, so the mask is all ones
        llc_sram_sp #(
            .WIDTH(llc_pkg::LINE_BITS),
            .DEPTH(llc_pkg::LLC_SETS)
        ) line_sram (
            .clk(clk),
            .ce(req.valid),
            .we(wr_line && req.way == llc_pkg::llc_way_t'(i)),
            .addr(req.set),
            .wdata(req.line),
            .wmask({llc_pkg::LINE_BITS{1'b1}}),
            .rdata(rd_line[i])
        );
    end

endmodule

// File: llc_way_select.sv
////////////////////////////////////////////////////////////////////////////
// tag compare and hit way choice, then a credited response buffer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module llc_way_select #(
    parameter int NUM_WAYS = llc_pkg::LLC_WAYS,
    parameter int RSP_DEPTH = 2
) (
    input logic clk,
    input logic rst,
    llc_mem_if.sel req,
    input logic [llc_pkg::MIXED_BITS-1:0] rd_mixed [NUM_WAYS],
    input llc_pkg::line_t rd_line [NUM_WAYS],
    input llc_pkg::llc_way_t rd_evict_way,
    input logic rsp_credit,
    output logic rsp_valid,
    output llc_pkg::llc_op_t rsp_op,
    output logic rsp_hit,
    output llc_pkg::llc_way_t rsp_way,
    output llc_pkg::llc_state_t rsp_state,
    output logic rsp_dirty,
    output llc_pkg::owner_t rsp_owner,
    output llc_pkg::line_t rsp_line,
    output llc_pkg::llc_way_t rsp_evict_way,
    output logic req_credit
);

    localparam int RSP_BITS = 2 + 1 + 2 * llc_pkg::LLC_WAY_BITS + llc_pkg::LLC_STATE_BITS +
        1 + llc_pkg::OWNER_BITS + llc_pkg::LINE_BITS;
    localparam int PTR_BITS = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(RSP_DEPTH + 1);
    // consumer may hold at most 255 ungiven slots
    localparam int GNT_BITS = 8;

    logic s1_valid;
    llc_pkg::llc_op_t s1_op;
    llc_pkg::llc_tag_t s1_tag;
    logic hit;
    llc_pkg::llc_way_t hit_way;
    logic [llc_pkg::MIXED_BITS-1:0] hit_word;
    llc_pkg::line_t hit_line;
    logic [RSP_BITS-1:0] sel_rsp;
    logic s2_valid;
    logic [RSP_BITS-1:0] s2_rsp;
    logic [RSP_BITS-1:0] buf_mem [RSP_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic [GNT_BITS-1:0] grants;
    logic [1:0] head_op;
    logic pop;

    // lowest valid way with a matching tag wins
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        hit_word = '0;
        hit_line = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (!hit && s1_op == llc_pkg::OP_LOOKUP &&
                rd_mixed[i][llc_pkg::MIXED_TAG_HI:llc_pkg::MIXED_TAG_LO] == s1_tag &&
                rd_mixed[i][llc_pkg::MIXED_STATE_HI:llc_pkg::MIXED_STATE_LO] != '0) begin
                hit = 1'b1;
                hit_way = llc_pkg::llc_way_t'(i);
                hit_word = rd_mixed[i];
                hit_line = rd_line[i];
            end
        end
    end

    assign sel_rsp = {s1_op, hit, hit_way,
                      hit_word[llc_pkg::MIXED_STATE_HI:llc_pkg::MIXED_STATE_LO],
                      hit_word[llc_pkg::MIXED_DIRTY_INDEX],
                      hit_word[llc_pkg::MIXED_OWNER_HI:llc_pkg::MIXED_OWNER_LO],
                      hit_line, rd_evict_way};

    assign pop = (count != '0) && (grants != '0);
    assign rsp_valid = pop;
    assign req_credit = pop;
    assign {head_op, rsp_hit, rsp_way, rsp_state, rsp_dirty, rsp_owner, rsp_line,
            rsp_evict_way} = buf_mem[rd_ptr];
    assign rsp_op = llc_pkg::llc_op_t'(head_op);

    always_ff @(posedge clk) begin
        s1_op <= req.op;
        s1_tag <= req.tag;
        s2_rsp <= sel_rsp;
        if (s2_valid) begin
            buf_mem[wr_ptr] <= s2_rsp;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            grants <= '0;
        end else begin
            s1_valid <= req.valid;
            s2_valid <= s1_valid;
            if (s2_valid) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_BITS'(s2_valid) - CNT_BITS'(pop);
            grants <= grants + GNT_BITS'(rsp_credit) - GNT_BITS'(pop);
        end
    end

endmodule

// File: llc_mem_top.sv
////////////////////////////////////////////////////////////////////////////
// LLC slice local memory top, credit flow control on both sides
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module llc_mem_top #(
    parameter int NUM_WAYS = llc_pkg::LLC_WAYS,
    parameter int RSP_DEPTH = 2
) (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input llc_pkg::llc_op_t req_op,
    input llc_pkg::llc_set_t req_set,
    input llc_pkg::llc_way_t req_way,
    input llc_pkg::llc_tag_t req_tag,
    input llc_pkg::llc_state_t req_state,
    input logic req_dirty,
    input llc_pkg::owner_t req_owner,
    input llc_pkg::line_t req_line,
    input llc_pkg::llc_way_t req_evict_way,
    input logic rsp_credit,
    output logic rsp_valid,
    output llc_pkg::llc_op_t rsp_op,
    output logic rsp_hit,
    output llc_pkg::llc_way_t rsp_way,
    output llc_pkg::llc_state_t rsp_state,
    output logic rsp_dirty,
    output llc_pkg::owner_t rsp_owner,
    output llc_pkg::line_t rsp_line,
    output llc_pkg::llc_way_t rsp_evict_way,
    output logic req_credit
);

    llc_mem_if mem_if ();

    logic [llc_pkg::MIXED_BITS-1:0] rd_mixed [NUM_WAYS];
    llc_pkg::line_t rd_line [NUM_WAYS];
    llc_pkg::llc_way_t rd_evict_way;

    // requests are never refused, so they go straight to the stores
    assign mem_if.valid = req_valid;
    assign mem_if.op = req_op;
    assign mem_if.set = req_set;
    assign mem_if.way = req_way;
    assign mem_if.tag = req_tag;
    assign mem_if.state = req_state;
    assign mem_if.dirty = req_dirty;
    assign mem_if.owner = req_owner;
    assign mem_if.line = req_line;
    assign mem_if.evict_way = req_evict_way;

    llc_tag_store #(.NUM_WAYS(NUM_WAYS)) u_tag_store (
        .clk(clk),
        .rst(rst),
        .req(mem_if.store),
        .rd_mixed(rd_mixed),
        .rd_evict_way(rd_evict_way)
    );

    llc_data_store #(.NUM_WAYS(NUM_WAYS)) u_data_store (
        .clk(clk),
        .req(mem_if.store),
        .rd_line(rd_line)
    );

    llc_way_select #(.NUM_WAYS(NUM_WAYS), .RSP_DEPTH(RSP_DEPTH)) u_way_select (
        .clk(clk),
        .rst(rst),
        .req(mem_if.sel),
        .rd_mixed(rd_mixed),
        .rd_line(rd_line),
        .rd_evict_way(rd_evict_way),
        .rsp_credit(rsp_credit),
        .rsp_valid(rsp_valid),
        .rsp_op(rsp_op),
        .rsp_hit(rsp_hit),
        .rsp_way(rsp_way),
        .rsp_state(rsp_state),
        .rsp_dirty(rsp_dirty),
        .rsp_owner(rsp_owner),
        .rsp_line(rsp_line),
        .rsp_evict_way(rsp_evict_way),
        .req_credit(req_credit)
    );

endmodule

// File: llc_mem_checker.sv
////////////////////////////////////////////////////////////////////////////
// reference model of the LLC local memory, checks every response in order
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module llc_mem_checker #(
    parameter int NUM_WAYS = llc_pkg::LLC_WAYS,
    parameter int RSP_DEPTH = 2,
    parameter int NAME_W = 160
) (
    input logic clk,
    input logic rst,
    input logic [NAME_W-1:0] req_name,
    input logic req_valid,
    input llc_pkg::llc_op_t req_op,
    input llc_pkg::llc_set_t req_set,
    input llc_pkg::llc_way_t req_way,
    input llc_pkg::llc_tag_t req_tag,
    input llc_pkg::llc_state_t req_state,
    input logic req_dirty,
    input llc_pkg::owner_t req_owner,
    input llc_pkg::line_t req_line,
    input llc_pkg::llc_way_t req_evict_way,
    input logic rsp_credit,
    input logic rsp_valid,
    input llc_pkg::llc_op_t rsp_op,
    input logic rsp_hit,
    input llc_pkg::llc_way_t rsp_way,
    input llc_pkg::llc_state_t rsp_state,
    input logic rsp_dirty,
    input llc_pkg::owner_t rsp_owner,
    input llc_pkg::line_t rsp_line,
    input llc_pkg::llc_way_t rsp_evict_way,
    input logic req_credit,
    output int tests_done,
    output int errors,
    output int pending
);

    localparam int RSP_W = 2 + 1 + 2 * llc_pkg::LLC_WAY_BITS + llc_pkg::LLC_STATE_BITS +
        1 + llc_pkg::OWNER_BITS + llc_pkg::LINE_BITS;

    logic m_filled [llc_pkg::LLC_SETS][NUM_WAYS];
    llc_pkg::llc_tag_t m_tag [llc_pkg::LLC_SETS][NUM_WAYS];
    llc_pkg::llc_state_t m_state [llc_pkg::LLC_SETS][NUM_WAYS];
    logic m_dirty [llc_pkg::LLC_SETS][NUM_WAYS];
    llc_pkg::owner_t m_owner [llc_pkg::LLC_SETS][NUM_WAYS];
    llc_pkg::line_t m_line [llc_pkg::LLC_SETS][NUM_WAYS];
    llc_pkg::llc_way_t m_evict [llc_pkg::LLC_SETS];
    logic [RSP_W-1:0] exp_q [$];
    logic [NAME_W-1:0] name_q [$];
    int spent;
    int returned;
    int grants_held;

    initial begin
        tests_done = 0;
        errors = 0;
        pending = 0;
        spent = 0;
        returned = 0;
        grants_held = 0;
        for (int s = 0; s < llc_pkg::LLC_SETS; s++) begin
            m_evict[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_filled[s][w] = 1'b0;
            end
        end
    end

    function automatic logic [RSP_W-1:0] pack_rsp(
        input logic [1:0] op, input logic hit, input llc_pkg::llc_way_t way,
        input llc_pkg::llc_state_t state, input logic dirty, input llc_pkg::owner_t owner,
        input llc_pkg::line_t line, input llc_pkg::llc_way_t evict
    );
        return {op, hit, way, state, dirty, owner, line, evict};
    endfunction

    function automatic string show(input logic [RSP_W-1:0] r);
        logic [1:0] op;
        logic hit;
        llc_pkg::llc_way_t way;
        llc_pkg::llc_state_t state;
        logic dirty;
        llc_pkg::owner_t owner;
        llc_pkg::line_t line;
        llc_pkg::llc_way_t evict;
        {op, hit, way, state, dirty, owner, line, evict} = r;
        return $sformatf("op=%0d hit=%0d way=%0d state=%0d dirty=%0d owner=%0d line=%h evict=%0d",
                         op, hit, way, state, dirty, owner, line, evict);
    endfunction

    // names arrive right-justified with leading zero bytes
    function automatic string name_text(input logic [NAME_W-1:0] v);
        string s;
        logic [7:0] c;
        s = "";
        for (int i = NAME_W / 8 - 1; i >= 0; i--) begin
            c = v[i*8 +: 8];
            if (c != 8'h00) begin
                s = $sformatf("%s%c", s, c);
            end
        end
        return s;
    endfunction

    task automatic model_request();
        logic hit;
        int hw;
        logic [RSP_W-1:0] exp;
        hit = 1'b0;
        hw = 0;
        if (req_op == llc_pkg::OP_SET_EVICT) begin
            m_evict[req_set] = req_evict_way;
        end
        // lowest way with a live matching tag
        if (req_op == llc_pkg::OP_LOOKUP) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (!hit && m_filled[req_set][w] && m_state[req_set][w] != '0 &&
                    m_tag[req_set][w] == req_tag) begin
                    hit = 1'b1;
                    hw = w;
                end
            end
        end
        if (hit) begin
            exp = pack_rsp(req_op, 1'b1, llc_pkg::llc_way_t'(hw), m_state[req_set][hw],
                           m_dirty[req_set][hw], m_owner[req_set][hw], m_line[req_set][hw],
                           m_evict[req_set]);
        end else begin
            exp = pack_rsp(req_op, 1'b0, '0, '0, 1'b0, '0, '0, m_evict[req_set]);
        end
        exp_q.push_back(exp);
        name_q.push_back(req_name);
        if (req_op == llc_pkg::OP_FILL) begin
            m_filled[req_set][req_way] = 1'b1;
            m_tag[req_set][req_way] = req_tag;
            m_owner[req_set][req_way] = req_owner;
            m_line[req_set][req_way] = req_line;
        end
        if (req_op == llc_pkg::OP_FILL || req_op == llc_pkg::OP_SET_STATE) begin
            m_state[req_set][req_way] = req_state;
            m_dirty[req_set][req_way] = req_dirty;
        end
    endtask

    task automatic check_response();
        logic [RSP_W-1:0] exp;
        logic [RSP_W-1:0] act;
        logic [NAME_W-1:0] name;
        if (grants_held == 0) begin
            errors++;
            $display("a response left without a grant from the consumer");
        end
        if (exp_q.size() == 0) begin
            errors++;
            $display("a response arrived with no request pending");
        end else begin
            exp = exp_q.pop_front();
            name = name_q.pop_front();
            act = pack_rsp(rsp_op, rsp_hit, rsp_way, rsp_state, rsp_dirty, rsp_owner,
                           rsp_line, rsp_evict_way);
            tests_done++;
            if (act !== exp) begin
                errors++;
                $display("Error %s: expected %s actual %s", name_text(name), show(exp),
                         show(act));
            end else begin
                $display("ok %s", name_text(name));
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            if (rsp_valid === 1'b1) begin
                check_response();
            end
            if (req_credit !== rsp_valid) begin
                errors++;
                $display("request credit pulse does not match a response leaving");
            end
            if (req_credit === 1'b1) begin
                returned++;
                if (returned > spent) begin
                    errors++;
                    $display("more request credits returned than requests issued");
                end
            end
            grants_held = grants_held + (rsp_credit ? 1 : 0) - (rsp_valid ? 1 : 0);
            if (req_valid === 1'b1) begin
                model_request();
                spent++;
                if (spent - returned > RSP_DEPTH) begin
                    errors++;
                    $display("requester has more requests outstanding than buffer slots");
                end
            end
            pending = exp_q.size();
        end
    end

endmodule

// File: tb_llc_mem.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the LLC local memory, table-driven with credit flow control
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_llc_mem;

    localparam int NUM_WAYS = llc_pkg::LLC_WAYS;
    localparam int RSP_DEPTH = 2;
    localparam int NAME_W = 160;
    localparam int MAX_TESTS = 32;
    localparam llc_pkg::llc_op_t LOOKUP = llc_pkg::OP_LOOKUP;
    localparam llc_pkg::llc_op_t FILL = llc_pkg::OP_FILL;
    localparam llc_pkg::llc_op_t SET_STATE = llc_pkg::OP_SET_STATE;
    localparam llc_pkg::llc_op_t SET_EVICT = llc_pkg::OP_SET_EVICT;

    logic clk = 1'b0;
    logic rst;
    logic req_valid;
    llc_pkg::llc_op_t req_op;
    llc_pkg::llc_set_t req_set;
    llc_pkg::llc_way_t req_way;
    llc_pkg::llc_tag_t req_tag;
    llc_pkg::llc_state_t req_state;
    logic req_dirty;
    llc_pkg::owner_t req_owner;
    llc_pkg::line_t req_line;
    llc_pkg::llc_way_t req_evict_way;
    logic rsp_credit;
    logic rsp_valid;
    llc_pkg::llc_op_t rsp_op;
    logic rsp_hit;
    llc_pkg::llc_way_t rsp_way;
    llc_pkg::llc_state_t rsp_state;
    logic rsp_dirty;
    llc_pkg::owner_t rsp_owner;
    llc_pkg::line_t rsp_line;
    llc_pkg::llc_way_t rsp_evict_way;
    logic req_credit;
    logic [NAME_W-1:0] cur_name;
    int tests_done;
    int errors;
    int pending;

    // stimulus table, one request per entry
    logic [NAME_W-1:0] t_name [MAX_TESTS];
    llc_pkg::llc_op_t t_op [MAX_TESTS];
    llc_pkg::llc_set_t t_set [MAX_TESTS];
    llc_pkg::llc_way_t t_way [MAX_TESTS];
    llc_pkg::llc_tag_t t_tag [MAX_TESTS];
    llc_pkg::llc_state_t t_state [MAX_TESTS];
    logic t_dirty [MAX_TESTS];
    llc_pkg::owner_t t_owner [MAX_TESTS];
    llc_pkg::line_t t_line [MAX_TESTS];
    llc_pkg::llc_way_t t_evict [MAX_TESTS];
    int t_grants [MAX_TESTS];
    int t_idle [MAX_TESTS];
    int n_tests = 0;
    logic table_ready = 1'b0;
    integer seed = 32'hd2ca_6f11;
    int issued = 0;
    int credits_back = 0;
    int grants_given = 0;

    always #20 clk = ~clk;

    llc_mem_top #(.NUM_WAYS(NUM_WAYS), .RSP_DEPTH(RSP_DEPTH)) DUT (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_op(req_op),
        .req_set(req_set), .req_way(req_way), .req_tag(req_tag), .req_state(req_state),
        .req_dirty(req_dirty), .req_owner(req_owner), .req_line(req_line),
        .req_evict_way(req_evict_way), .rsp_credit(rsp_credit), .rsp_valid(rsp_valid),
        .rsp_op(rsp_op), .rsp_hit(rsp_hit), .rsp_way(rsp_way), .rsp_state(rsp_state),
        .rsp_dirty(rsp_dirty), .rsp_owner(rsp_owner), .rsp_line(rsp_line),
        .rsp_evict_way(rsp_evict_way), .req_credit(req_credit)
    );

    llc_mem_checker #(.NUM_WAYS(NUM_WAYS), .RSP_DEPTH(RSP_DEPTH), .NAME_W(NAME_W)) u_checker (
        .clk(clk), .rst(rst), .req_name(cur_name), .req_valid(req_valid), .req_op(req_op),
        .req_set(req_set), .req_way(req_way), .req_tag(req_tag), .req_state(req_state),
        .req_dirty(req_dirty), .req_owner(req_owner), .req_line(req_line),
        .req_evict_way(req_evict_way), .rsp_credit(rsp_credit), .rsp_valid(rsp_valid),
        .rsp_op(rsp_op), .rsp_hit(rsp_hit), .rsp_way(rsp_way), .rsp_state(rsp_state),
        .rsp_dirty(rsp_dirty), .rsp_owner(rsp_owner), .rsp_line(rsp_line),
        .rsp_evict_way(rsp_evict_way), .req_credit(req_credit),
        .tests_done(tests_done), .errors(errors), .pending(pending)
    );

    // request credits handed back by the DUT
    always @(posedge clk) begin
        if (req_credit === 1'b1) begin
            credits_back <= credits_back + 1;
        end
    end

    task automatic add_test(input logic [NAME_W-1:0] name, input llc_pkg::llc_op_t op,
                            input int set_idx, input int way_idx, input int tag,
                            input int st, input int dty, input int own, input int ev,
                            input int grants, input int idle);
        t_name[n_tests] = name;
        t_op[n_tests] = op;
        t_set[n_tests] = llc_pkg::llc_set_t'(set_idx);
        t_way[n_tests] = llc_pkg::llc_way_t'(way_idx);
        t_tag[n_tests] = llc_pkg::llc_tag_t'(tag);
        t_state[n_tests] = llc_pkg::llc_state_t'(st);
        t_dirty[n_tests] = dty[0];
        t_owner[n_tests] = llc_pkg::owner_t'(own);
        t_line[n_tests] = $random(seed);
        t_evict[n_tests] = llc_pkg::llc_way_t'(ev);
        t_grants[n_tests] = grants;
        t_idle[n_tests] = idle;
        n_tests++;
    endtask

    // name, op, set, way, tag, state, dirty, owner, evict, grants, idle
    task automatic build_table();
        add_test("evict_reset", LOOKUP, 9, 0, 8'h11, 0, 0, 0, 0, 1, 0);
        add_test("fill_w0", FILL, 3, 0, 8'h10, 1, 0, 0, 0, 1, 0);
        add_test("fill_w1", FILL, 3, 1, 8'h21, 2, 1, 1, 0, 1, 0);
        add_test("fill_w2", FILL, 3, 2, 8'h32, 3, 0, 2, 0, 1, 0);
        add_test("fill_w3", FILL, 3, 3, 8'h43, 4, 1, 3, 0, 1, 0);
        add_test("look_w0", LOOKUP, 3, 0, 8'h10, 0, 0, 0, 0, 1, 0);
        add_test("look_w1", LOOKUP, 3, 0, 8'h21, 0, 0, 0, 0, 1, 0);
        add_test("look_w2", LOOKUP, 3, 0, 8'h32, 0, 0, 0, 0, 1, 0);
        add_test("look_w3", LOOKUP, 3, 0, 8'h43, 0, 0, 0, 0, 1, 0);
        add_test("look_miss", LOOKUP, 3, 0, 8'h55, 0, 0, 0, 0, 1, 0);
        // tag and owner in the request must be ignored by the masked write
        add_test("state_w1", SET_STATE, 3, 1, 8'hff, 5, 0, 3, 0, 1, 0);
        add_test("look_after_state", LOOKUP, 3, 0, 8'h21, 0, 0, 0, 0, 1, 0);
        add_test("state_zero_w2", SET_STATE, 3, 2, 8'h32, 0, 0, 2, 0, 1, 0);
        add_test("look_invalid_w2", LOOKUP, 3, 0, 8'h32, 0, 0, 0, 0, 1, 0);
        add_test("evict_set3", SET_EVICT, 3, 0, 8'h00, 0, 0, 0, 2, 1, 0);
        add_test("evict_set12", SET_EVICT, 12, 0, 8'h00, 0, 0, 0, 5, 1, 0);
        add_test("look_evict_set3", LOOKUP, 3, 0, 8'h10, 0, 0, 0, 0, 1, 0);
        add_test("look_evict_set12", LOOKUP, 12, 0, 8'h10, 0, 0, 0, 0, 1, 0);
        add_test("look_evict_other", LOOKUP, 4, 0, 8'h10, 0, 0, 0, 0, 1, 0);
        add_test("fill_old", FILL, 7, 1, 8'h7a, 1, 0, 0, 0, 1, 0);
        add_test("fill_then_look", FILL, 7, 1, 8'h7a, 2, 1, 2, 0, 1, 4);
        add_test("look_next_cycle", LOOKUP, 7, 0, 8'h7a, 0, 0, 0, 0, 1, 0);
        add_test("dup_fill_w2", FILL, 5, 2, 8'h66, 3, 0, 1, 0, 1, 0);
        add_test("dup_fill_w1", FILL, 5, 1, 8'h66, 1, 1, 0, 0, 1, 0);
        add_test("dup_look", LOOKUP, 5, 0, 8'h66, 0, 0, 0, 0, 1, 0);
        // two requests with grants withheld, then released together
        add_test("bp_first", LOOKUP, 3, 0, 8'h10, 0, 0, 0, 0, 0, 4);
        add_test("bp_second", LOOKUP, 3, 0, 8'h43, 0, 0, 0, 0, 0, 0);
        add_test("bp_release", LOOKUP, 3, 0, 8'h21, 0, 0, 0, 0, 3, 6);
        add_test("bp_after", LOOKUP, 7, 0, 8'h7a, 0, 0, 0, 0, 1, 0);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        req_valid = 1'b0;
        rsp_credit = 1'b0;
    endtask

    task automatic drive_request(input int i);
        req_valid = 1'b1;
        req_op = t_op[i];
        req_set = t_set[i];
        req_way = t_way[i];
        req_tag = t_tag[i];
        req_state = t_state[i];
        req_dirty = t_dirty[i];
        req_owner = t_owner[i];
        req_line = t_line[i];
        req_evict_way = t_evict[i];
        cur_name = t_name[i];
        issued++;
    endtask

    initial begin
        int g;
        rst = 1'b0;
        req_valid = 1'b0;
        req_op = LOOKUP;
        req_set = '0;
        req_way = '0;
        req_tag = '0;
        req_state = '0;
        req_dirty = 1'b0;
        req_owner = '0;
        req_line = '0;
        req_evict_way = '0;
        rsp_credit = 1'b0;
        cur_name = '0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            next_cycle();
            repeat (t_idle[i]) next_cycle();
            for (g = 0; g < t_grants[i]; g++) begin
                if (g > 0) begin
                    next_cycle();
                end
                rsp_credit = 1'b1;
                grants_given++;
            end
            while (issued - credits_back >= RSP_DEPTH) begin
                next_cycle();
            end
            drive_request(i);
        end
        // fund whatever is still waiting in the buffer
        while (grants_given < issued) begin
            next_cycle();
            rsp_credit = 1'b1;
            grants_given++;
        end
        next_cycle();
        while (pending != 0) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        $display("tests finished %0d of %0d, errors %0d", tests_done, n_tests, errors);
        if (errors == 0 && tests_done == n_tests) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (table_ready);
        repeat (n_tests * 20) @(posedge clk);
        $display("run did not finish within %0d cycles, %0d responses still missing",
                 n_tests * 20, pending);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: build.f
llc_pkg.sv
llc_mem_if.sv
llc_sram_sp.sv
llc_tag_store.sv
llc_data_store.sv
llc_way_select.sv
llc_mem_top.sv
llc_mem_checker.sv
tb_llc_mem.sv
